//--- sim/rasterCases.txt
# prim(0 fill, 1 rect) x0 y0 width height color(hex) checkMask stencil(bin) stallPct
# expectedCommands expectedFlush
0 0 0 16 2 7c1f 0 00 0 4 0
0 5 10 20 3 03e0 0 00 0 12 0
0 5 10 20 3 03e0 0 00 40 12 0
0 1000 1020 24 4 001f 0 00 0 12 0
1 3 4 6 2 1234 0 00 0 8 1
1 2 0 5 3 7fff 0 00 0 9 1
1 3 4 6 2 0abc 1 01 0 6 1
1 3 4 6 2 0abc 1 11 0 0 1
1 3 4 6 2 0abc 1 10 0 6 1
1 3 4 6 2 0abc 0 11 0 8 1
0 10 10 0 5 5555 0 00 0 0 0
0 10 10 5 0 5555 0 00 0 0 0
1 4 4 0 3 2aaa 0 00 0 0 0
1 4 4 3 0 2aaa 0 00 0 0 0
1 3 4 6 2 1234 0 00 50 8 1
1 2 0 5 3 7fff 0 00 70 9 1
0 1000 1020 24 4 001f 0 00 60 12 0
1 1022 1022 2 2 4321 0 00 0 2 1
1 1 1 1 1 0f0f 0 00 0 1 1

//--- vlog.f
logic/renderPkg.sv
logic/geomPkg.sv
logic/scanCtrlIf.sv
logic/renderSequencer.sv
logic/scanPosition.sv
logic/memCommandOut.sv
logic/rasterTop.sv
sim/rasterTb.sv

//--- Bender.yml
package:
  name: raster

sources:
  - logic/renderPkg.sv
  - logic/geomPkg.sv
  - logic/scanCtrlIf.sv
  - logic/renderSequencer.sv
  - logic/scanPosition.sv
  - logic/memCommandOut.sv
  - logic/rasterTop.sv
  - target: simulation
    files:
      - sim/rasterTb.sv

//--- sim/rasterTb.sv
// Case file driven testbench; run from the project root so that sim/rasterCases.txt is found
`default_nettype none
`timescale 1ns/1ps

module rasterTb
	import renderPkg::*, geomPkg::*;
();

	localparam int CASE_TIMEOUT = 2000;  // Cycles allowed per render

	logic       clk, rst, startFill, startRect, checkMask;
	logic       fifoAccept, requestNextPixel, memBusy;
	coord_t     x0, y0, width, height;
	color_t     color;
	logic [1:0] stencil;
	logic       cmdValid, flush, inactiveNext;
	cmdKind_t   cmdKind;
	vramAddr_t  cmdAddr;
	color_t     cmdColor;
	logic [1:0] writeMask;

	logic [21:0] expQ[$];                // {kind, mask, address} per command
	integer      seed;
	int          fd, n, testNum, passCount, failCount, caseErrors;
	int          prim, cx0, cy0, cw, ch, ccol, cchk, dens, expCount, expFlush;
	logic [1:0]  cst;
	logic        timedOut, fileErr;
	string       lineStr;

	rasterTop #(.FILL_SEGMENT(8)) i_dut (
		.i_clk(clk), .i_rst(rst), .i_startFill(startFill), .i_startRect(startRect),
		.i_x0(x0), .i_y0(y0), .i_width(width), .i_height(height), .i_color(color),
		.i_checkMask(checkMask), .i_stencil(stencil), .i_fifoAccept(fifoAccept),
		.i_requestNextPixel(requestNextPixel), .i_memBusy(memBusy),
		.o_cmdValid(cmdValid), .o_cmdKind(cmdKind), .o_cmdAddr(cmdAddr),
		.o_cmdColor(cmdColor), .o_writeMask(writeMask), .o_flush(flush),
		.o_renderInactiveNextCycle(inactiveNext)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;           // 10 ns period
	end

	// ----------------------------------------
	// Reference model and helpers
	// ----------------------------------------
	function automatic vramAddr_t pairAddress(input int x, input int y);
		return vramAddr_t'(y * VRAM_PAIRS_PER_LINE + x / 2);
	endfunction

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("mismatch %s: got %h expected %h", name, got, exp);
		caseErrors++;
	endtask

	task automatic checkLowAfterReset(input string name, input logic value);
		if (value !== 1'b0) begin
			$display("mismatch %s after reset: got %h expected 0", name, value);
			failCount++;
		end
	endtask

	// Expected command list straight from the geometry
	task automatic buildExpected(input int kind);
		int         x, y, right, bottom;
		logic [1:0] m;
		expQ.delete();
		right  = x0 + width - 1;
		bottom = y0 + height - 1;
		if (width == 0 || height == 0)
			return;                      // Rejected primitive
		for (y = y0; y <= bottom; y++) begin
			if (kind == 0) begin
				for (x = x0 & ~7; x <= right; x += 8)  // Segments from aligned left edge
					expQ.push_back({CMD_FILL, 2'b11, pairAddress(x, y)});
			end else begin
				for (x = x0 & ~1; x <= right; x += 2) begin
					m[0] = x >= x0;
					m[1] = (x + 1 >= x0) && (x + 1 <= right);
					if (checkMask)
						m = m & ~stencil;    // Stencil bit set blocks the pixel
					if (m != 2'b00)
						expQ.push_back({CMD_PAIR, m, pairAddress(x, y)});
				end
			end
		end
	endtask

	// One render from start strobe to end pulse plus a short tail
	task automatic runCase(input int kind, input int density);
		int          cyc, got, flushes, pulses, tail, busyHold;
		logic [21:0] exp;
		logic        ended, accept;
		got      = 0;
		flushes  = 0;
		pulses   = 0;
		tail     = 0;
		busyHold = 0;
		ended = 1'b0;
		caseErrors = 0;
		buildExpected(kind);
		@(posedge clk); #1;
		startFill        = (kind == 0);
		startRect        = (kind == 1);
		memBusy          = (kind == 1);  // Busy until the commands drain
		fifoAccept       = 1'b1;
		requestNextPixel = 1'b1;
		for (cyc = 0; cyc < CASE_TIMEOUT && tail < 4; cyc++) begin
			@(negedge clk);              // Outputs are stable here
			if (cmdValid) begin
				if (got < expQ.size()) begin
					exp = expQ[got];
					if (cmdKind !== exp[21])
						reportMismatch("o_cmdKind", cmdKind, exp[21]);
					if (writeMask !== exp[20:19])
						reportMismatch("o_writeMask", writeMask, exp[20:19]);
					if (cmdAddr !== exp[18:0])
						reportMismatch("o_cmdAddr", cmdAddr, exp[18:0]);
				end else begin
					$display("command issued beyond the expected list");
					caseErrors++;
				end
				if (cmdColor !== color)
					reportMismatch("o_cmdColor", cmdColor, color);
				got++;
			end
			if (flush) begin
				flushes++;
				if (memBusy) begin
					$display("flush reported while memory still busy");
					caseErrors++;
				end
			end
			if (inactiveNext) begin
				pulses++;
				ended = 1'b1;
			end
			if (ended)
				tail++;
			@(posedge clk); #1;
			startFill = 1'b0;
			startRect = 1'b0;
			accept = (density == 0) || (($unsigned($random(seed)) % 100) >= density);
			fifoAccept       = accept;
			requestNextPixel = accept;
			if (kind == 1 && got >= expQ.size())
				busyHold++;
			memBusy = (kind == 1) && (busyHold < 3);  // Drops a few cycles after last command
			// Other primitive started while busy must be ignored
			if (density != 0 && cyc == 4 && !ended) begin
				startFill = (kind == 1);
				startRect = (kind == 0);
			end
		end
		if (!ended) begin
			$display("timeout: render did not end within %0d cycles", CASE_TIMEOUT);
			timedOut = 1'b1;
			caseErrors++;
		end
		if (got != expQ.size())
			reportMismatch("o_cmdValid count vs model", got, expQ.size());
		if (got != expCount)
			reportMismatch("o_cmdValid count vs case file", got, expCount);
		if (flushes != expFlush)
			reportMismatch("o_flush pulses", flushes, expFlush);
		if (pulses != 1)
			reportMismatch("o_renderInactiveNextCycle pulses", pulses, 1);
		$display("test %0d %s: %0d commands, %0d flush, %s", testNum,
			(kind == 0) ? "fill" : "rect", got, flushes, (caseErrors == 0) ? "ok" : "FAIL");
		if (caseErrors == 0)
			passCount++;
		else
			failCount++;
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		seed = 44718;
		testNum   = 0;
		passCount = 0;
		failCount = 0;
		timedOut = 1'b0;
		fileErr  = 1'b0;
		rst       = 1'b1;
		startFill = 1'b0;
		startRect = 1'b0;
		checkMask = 1'b0;
		fifoAccept       = 1'b1;
		requestNextPixel = 1'b1;
		memBusy          = 1'b0;
		x0      = '0;
		y0      = '0;
		width   = '0;
		height  = '0;
		color   = '0;
		stencil = '0;
		repeat (4) @(posedge clk);
		#1 rst = 1'b0;
		@(negedge clk);
		checkLowAfterReset("o_cmdValid", cmdValid);
		checkLowAfterReset("o_flush", flush);
		checkLowAfterReset("o_renderInactiveNextCycle", inactiveNext);
		fd = $fopen("sim/rasterCases.txt", "r");
		if (fd == 0) begin
			$display("cannot open case file sim/rasterCases.txt");
			fileErr = 1'b1;
		end else begin
			while (!$feof(fd) && !timedOut) begin
				lineStr = "";
				n = $fgets(lineStr, fd);
				if (n > 0 && lineStr.len() > 1 && lineStr[0] != "#") begin
					n = $sscanf(lineStr, "%d %d %d %d %d %h %d %b %d %d %d", prim, cx0, cy0,
						cw, ch, ccol, cchk, cst, dens, expCount, expFlush);
					if (n == 11) begin
						@(posedge clk); #1;
						x0     = cx0;            // Held through the render
						y0     = cy0;
						width  = cw;
						height = ch;
						color     = ccol[14:0];
						checkMask = cchk[0];
						stencil   = cst;
						testNum++;
						runCase(prim, dens);
					end
				end
			end
			$fclose(fd);
		end
		$display("tests %0d, passed %0d, failed %0d", testNum, passCount, failCount);
		if (failCount == 0 && !timedOut && !fileErr && testNum > 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/rasterTop.sv
// Fill and rectangle rasterizer top; all inputs except the strobes must hold between starts
`default_nettype none
`timescale 1ns/1ps

module rasterTop
	import renderPkg::*, geomPkg::*;
#(
	parameter int FILL_SEGMENT = 8           // Pixels per fill command
) (
	input  logic       i_clk,
	input  logic       i_rst,
	input  logic       i_startFill,
	input  logic       i_startRect,
	input  coord_t     i_x0,
	input  coord_t     i_y0,
	input  coord_t     i_width,
	input  coord_t     i_height,
	input  color_t     i_color,
	input  logic       i_checkMask,
	input  logic [1:0] i_stencil,
	input  logic       i_fifoAccept,
	input  logic       i_requestNextPixel,
	input  logic       i_memBusy,
	output logic       o_cmdValid,
	output cmdKind_t   o_cmdKind,
	output vramAddr_t  o_cmdAddr,
	output color_t     o_cmdColor,
	output logic [1:0] o_writeMask,
	output logic       o_flush,
	output logic       o_renderInactiveNextCycle
);

	scanCtrlIf  ctrl ();
	logic       issue, inFlight;
	cmdKind_t   kind;
	logic [1:0] mask;

	renderSequencer uSequencer (
		.i_clk(i_clk), .i_rst(i_rst), .i_startFill(i_startFill), .i_startRect(i_startRect),
		.i_width(i_width), .i_height(i_height), .i_checkMask(i_checkMask),
		.i_stencil(i_stencil), .i_fifoAccept(i_fifoAccept),
		.i_requestNextPixel(i_requestNextPixel), .i_memBusy(i_memBusy), .i_inFlight(inFlight),
		.ctrl(ctrl), .o_issue(issue), .o_kind(kind), .o_mask(mask), .o_flush(o_flush),
		.o_renderInactiveNextCycle(o_renderInactiveNextCycle)
	);

	scanPosition #(.FILL_SEGMENT(FILL_SEGMENT)) uScan (
		.i_clk(i_clk), .i_rst(i_rst), .i_x0(i_x0), .i_y0(i_y0),
		.i_width(i_width), .i_height(i_height), .ctrl(ctrl)
	);

	// Command takes the position the FSM decided on
	memCommandOut uCmdOut (
		.i_clk(i_clk), .i_rst(i_rst), .i_issue(issue), .i_kind(kind), .i_mask(mask),
		.i_x(ctrl.curX), .i_y(ctrl.curY), .i_color(i_color), .o_inFlight(inFlight),
		.o_cmdValid(o_cmdValid), .o_cmdKind(o_cmdKind), .o_cmdAddr(o_cmdAddr),
		.o_cmdColor(o_cmdColor), .o_writeMask(o_writeMask)
	);

endmodule

`default_nettype wire

//--- logic/memCommandOut.sv
// Command output register; valid doubles as the in-flight flag and fill always writes both pixels
`default_nettype none
`timescale 1ns/1ps

module memCommandOut
	import renderPkg::*, geomPkg::*;
(
	input  logic       i_clk,
	input  logic       i_rst,
	input  logic       i_issue,
	input  cmdKind_t   i_kind,
	input  logic [1:0] i_mask,
	input  coord_t     i_x,
	input  coord_t     i_y,
	input  color_t     i_color,
	output logic       o_inFlight,
	output logic       o_cmdValid,
	output cmdKind_t   o_cmdKind,
	output vramAddr_t  o_cmdAddr,
	output color_t     o_cmdColor,
	output logic [1:0] o_writeMask
);

	vramAddr_t pairAddr;

	// Line stride in pairs plus X halved
	assign pairAddr = vramAddr_t'(i_y) * vramAddr_t'(VRAM_PAIRS_PER_LINE) + vramAddr_t'(i_x >> 1);

	always_ff @(posedge i_clk) begin
		if (i_rst)
			o_cmdValid <= 1'b0;
		else
			o_cmdValid <= i_issue;            // One cycle after the FSM decision
	end

	// Payload
	always_ff @(posedge i_clk) begin
		if (i_issue) begin
			o_cmdKind   <= i_kind;
			o_cmdAddr   <= pairAddr;
			o_cmdColor  <= i_color;
			o_writeMask <= (i_kind == CMD_FILL) ? 2'b11 : i_mask;
		end
	end

	assign o_inFlight = o_cmdValid;

	pairMaskNonZero: assert property (@(posedge i_clk) disable iff (i_rst)
		(o_cmdValid && o_cmdKind == CMD_PAIR) |-> (o_writeMask != 2'b00))
		else $error("Pair command with empty write mask");

endmodule

`default_nettype wire

//--- logic/scanPosition.sv
// Scan X/Y counter; FILL_SEGMENT must be a power of two and the area must end inside 1024x1024
`default_nettype none
`timescale 1ns/1ps

module scanPosition
	import renderPkg::*, geomPkg::*;
#(
	parameter int FILL_SEGMENT = 8
) (
	input  logic    i_clk,
	input  logic    i_rst,
	input  coord_t  i_x0,
	input  coord_t  i_y0,
	input  coord_t  i_width,
	input  coord_t  i_height,
	scanCtrlIf.scan ctrl
);

	localparam coord_t SEG_MASK = ~coord_t'(FILL_SEGMENT - 1);

	logic [10:0] posX, posY;         // One extra bit so stepping past 1023 does not wrap
	logic [10:0] leftEdge, rightEdge, lastLine;
	logic [10:0] alignedLeft, stepX, pairRight;
	logic [11:0] segEnd;

	// ----------------------------------------
	// Held geometry
	// ----------------------------------------
	assign leftEdge  = {1'b0, i_x0};
	assign rightEdge = {1'b0, i_x0} + {1'b0, i_width} - 11'd1;  // Inclusive
	assign lastLine  = {1'b0, i_y0} + {1'b0, i_height} - 11'd1;

	// Segment aligned for fill, even pixel for pairs
	assign alignedLeft = ctrl.isFill ? {1'b0, i_x0 & SEG_MASK} : {1'b0, i_x0[9:1], 1'b0};
	assign stepX       = ctrl.isFill ? 11'(FILL_SEGMENT) : 11'd2;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			posX <= '0;
			posY <= '0;
		end else if (ctrl.loadNext) begin
			case (ctrl.selX)
				X_LEFT:  posX <= alignedLeft;
				X_NEXT:  posX <= posX + stepX;
				default: posX <= posX;
			endcase
			case (ctrl.selY)
				Y_START: posY <= {1'b0, i_y0};
				Y_NEXT:  posY <= posY + 11'd1;
				default: posY <= posY;
			endcase
		end
	end

	// ----------------------------------------
	// Bound flags from registered position
	// ----------------------------------------
	assign segEnd    = {1'b0, posX} + 12'(FILL_SEGMENT); // First X after segment
	assign pairRight = posX + 11'd1;

	assign ctrl.lastSegment  = segEnd > {1'b0, rightEdge};
	assign ctrl.endVertical  = posY == lastLine;
	assign ctrl.insideBottom = posY <= lastLine;
	assign ctrl.pairInside   = posX <= rightEdge;
	assign ctrl.insideL      = (posX >= leftEdge) && (posX <= rightEdge);
	assign ctrl.insideR      = (pairRight >= leftEdge) && (pairRight <= rightEdge);
	assign ctrl.curX         = posX[9:0];
	assign ctrl.curY         = posY[9:0];

	// Sequencer only steps Y from a line inside the area
	yStepInside: assert property (@(posedge i_clk) disable iff (i_rst)
		(ctrl.loadNext && ctrl.selY == Y_NEXT) |-> (posY <= lastLine))
		else $error("Y stepped from beyond last line");

endmodule

`default_nettype wire

//--- logic/renderSequencer.sv
// Fill and rectangle render FSM; starts are sampled in IDLE only and geometry must stay steady
`default_nettype none
`timescale 1ns/1ps

module renderSequencer
	import renderPkg::*, geomPkg::*;
(
	input  logic         i_clk,
	input  logic         i_rst,
	input  logic         i_startFill,
	input  logic         i_startRect,
	input  coord_t       i_width,
	input  coord_t       i_height,
	input  logic         i_checkMask,
	input  logic [1:0]   i_stencil,          // Bit 0 left pixel, bit 1 right pixel
	input  logic         i_fifoAccept,
	input  logic         i_requestNextPixel,
	input  logic         i_memBusy,
	input  logic         i_inFlight,
	scanCtrlIf.sequencer ctrl,
	output logic         o_issue,
	output cmdKind_t     o_kind,
	output logic [1:0]   o_mask,
	output logic         o_flush,
	output logic         o_renderInactiveNextCycle
);

	renderState_t currState, nextState;
	logic         emptyArea;
	logic [1:0]   pairMask;

	always_ff @(posedge i_clk) begin
		if (i_rst)
			currState <= IDLE;
		else
			currState <= nextState;
	end

	assign emptyArea = (i_width == '0) || (i_height == '0);

	// Pixel written if inside and stencil clear when checking
	assign pairMask[0] = ctrl.insideL & (~i_checkMask | ~i_stencil[0]);
	assign pairMask[1] = ctrl.insideR & (~i_checkMask | ~i_stencil[1]);

	assign ctrl.isFill = (currState == FILL_START) || (currState == FILL_LINE);
	assign o_kind      = ctrl.isFill ? CMD_FILL : CMD_PAIR;
	assign o_mask      = pairMask;

	always_comb begin
		nextState     = currState;
		ctrl.loadNext = 1'b0;
		ctrl.selX     = X_ASIS;
		ctrl.selY     = Y_ASIS;
		o_issue       = 1'b0;
		o_flush       = 1'b0;
		case (currState)
			IDLE: begin
				if (i_startFill)
					nextState = FILL_START;
				else if (i_startRect)
					nextState = RECT_START;
			end
			// ----------------------------------------
			// Fill
			// ----------------------------------------
			FILL_START: begin
				if (emptyArea) begin
					nextState = IDLE;          // Rejected without flush
				end else begin
					ctrl.loadNext = 1'b1;
					ctrl.selX     = X_LEFT;
					ctrl.selY     = Y_START;
					nextState     = FILL_LINE;
				end
			end
			FILL_LINE: begin
				if (i_fifoAccept) begin        // Hold everything while FIFO refuses
					o_issue = 1'b1;
					if (ctrl.lastSegment) begin
						if (ctrl.endVertical) begin
							nextState = IDLE;      // Fill ends without flush
						end else begin
							ctrl.loadNext = 1'b1;
							ctrl.selX     = X_LEFT;
							ctrl.selY     = Y_NEXT;
						end
					end else begin
						ctrl.loadNext = 1'b1;
						ctrl.selX     = X_NEXT;
					end
				end
			end
			// ----------------------------------------
			// Rectangle
			// ----------------------------------------
			RECT_START: begin
				if (emptyArea) begin
					nextState = IDLE;
				end else begin
					ctrl.loadNext = 1'b1;
					ctrl.selX     = X_LEFT;
					ctrl.selY     = Y_START;
					nextState     = RECT_SCAN_LINE;
				end
			end
			RECT_SCAN_LINE: begin
				if (!ctrl.insideBottom) begin
					nextState = FLUSH_COMPLETE;
				end else if (ctrl.pairInside) begin
					if (i_requestNextPixel) begin
						o_issue       = |pairMask; // Fully masked pair is skipped
						ctrl.loadNext = 1'b1;
						ctrl.selX     = X_NEXT;
					end
				end else begin
					ctrl.loadNext = 1'b1;        // Wrap to next line
					ctrl.selX     = X_LEFT;
					ctrl.selY     = Y_NEXT;
				end
			end
			FLUSH_COMPLETE: begin
				if (!i_memBusy && !i_inFlight) begin
					o_flush   = 1'b1;
					nextState = IDLE;
				end
			end
			default: nextState = IDLE;
		endcase
	end

	assign o_renderInactiveNextCycle = (currState != IDLE) && (nextState == IDLE);

	issueInScanState: assert property (@(posedge i_clk) disable iff (i_rst)
		o_issue |-> (currState == FILL_LINE) || (currState == RECT_SCAN_LINE))
		else $error("Command issued outside a scan state");

	noLoadInIdle: assert property (@(posedge i_clk) disable iff (i_rst)
		(currState == IDLE) |-> !ctrl.loadNext)
		else $error("Position load while idle");

endmodule

`default_nettype wire

//--- logic/scanCtrlIf.sv
// Position control between render FSM and scan counter; selects only take effect with loadNext
`default_nettype none
`timescale 1ns/1ps

interface scanCtrlIf
	import renderPkg::*, geomPkg::*;
();

	// Sequencer to scan counter
	logic   loadNext;     // Apply selX and selY this cycle
	selX_t  selX;
	selY_t  selY;
	logic   isFill;       // Segment step instead of pair step

	// Scan counter feedback
	logic   lastSegment;  // Current segment reaches right edge
	logic   endVertical;  // On last line
	logic   insideBottom; // Y not past last line
	logic   pairInside;   // Pair left X at or before right edge
	logic   insideL;
	logic   insideR;
	coord_t curX;
	coord_t curY;

	modport sequencer (
		output loadNext, selX, selY, isFill,
		input  lastSegment, endVertical, insideBottom, pairInside, insideL, insideR
	);

	modport scan (
		input  loadNext, selX, selY, isFill,
		output lastSegment, endVertical, insideBottom, pairInside, insideL, insideR, curX, curY
	);

endinterface

`default_nettype wire

//--- logic/geomPkg.sv
// VRAM geometry types; coordinates are 10 bit and lines hold 512 pixel pairs
`default_nettype none

package geomPkg;

	// ----------------------------------------
	// Pixel and address types
	// ----------------------------------------
	typedef logic [9:0]  coord_t;    // X or Y pixel coordinate
	typedef logic [14:0] color_t;    // 5:5:5 BGR
	typedef logic [18:0] vramAddr_t; // Pair address in VRAM

	// One VRAM line is 1024 pixels stored as pairs
	localparam int VRAM_PAIRS_PER_LINE = 512;

	// Address of the pair that holds pixel (x, y)
	// Pair index is X halved, line stride in pairs
	// 19 bits cover 1024 lines of 512 pairs
	// Odd X maps to the same pair as X minus one

endpackage

`default_nettype wire

//--- logic/renderPkg.sv
// Render FSM state and scan select encodings; values are shared by sequencer and scan counter
`default_nettype none

package renderPkg;

	// ----------------------------------------
	// Sequencer states
	// ----------------------------------------
	typedef enum logic [2:0] {
		IDLE           = 3'd0, // Waiting for a start strobe
		FILL_START     = 3'd1, // Empty check and position load
		FILL_LINE      = 3'd2, // One fill command per segment
		RECT_START     = 3'd3, // Zero size check and position load
		RECT_SCAN_LINE = 3'd4, // Pair scan under consumer request
		FLUSH_COMPLETE = 3'd5  // Wait for memory and command drain
	} renderState_t;

	// Next X choice, only applied with loadNext
	typedef enum logic [1:0] {
		X_ASIS = 2'd0,
		X_LEFT = 2'd1, // Left edge aligned to segment or pair
		X_NEXT = 2'd2  // Step by segment or by pair
	} selX_t;

	// Next Y choice
	typedef enum logic [1:0] {
		Y_ASIS  = 2'd0,
		Y_START = 2'd1,
		Y_NEXT  = 2'd2
	} selY_t;

	typedef enum logic {
		CMD_FILL = 1'b0, // Segment fill with full mask
		CMD_PAIR = 1'b1  // Pixel pair write with per pixel mask
	} cmdKind_t;

endpackage

`default_nettype wire
